// ==== glb_reg_pkg.sv ====
// global buffer register map
package glb_reg_pkg;

    // word offsets in the configuration space
    typedef enum logic [3:0] {
        REG_CTRL     = 4'h0,
        REG_ST_ADDR  = 4'h1,
        REG_ST_COUNT = 4'h2,
        REG_LD_ADDR  = 4'h3,
        REG_LD_COUNT = 4'h4,
        REG_STATUS   = 4'h5
    } reg_addr_e;

    // REG_CTRL, write 1 to start, bits self-clear
    localparam int CTRL_ST_START_BIT = 0;
    localparam int CTRL_LD_START_BIT = 1;

    // REG_STATUS layout
    // busy bits are live, done bits sticky and write-1-to-clear
    localparam int STATUS_ST_BUSY_BIT = 0;
    localparam int STATUS_LD_BUSY_BIT = 1;
    localparam int STATUS_ST_DONE_BIT = 2;
    localparam int STATUS_LD_DONE_BIT = 3;

endpackage

// ==== glb_dma_pkg.sv ====
// global buffer dma and bank types
package glb_dma_pkg;

    // dma sequencing states
    typedef enum logic [1:0] {
        DMA_IDLE  = 2'd0,
        DMA_RUN   = 2'd1,
        DMA_DRAIN = 2'd2
    } dma_state_e;

    // bank requesters, also the grant owner
    typedef enum logic [1:0] {
        PORT_NONE  = 2'd0,
        PORT_STORE = 2'd1,
        PORT_LOAD  = 2'd2,
        PORT_HOST  = 2'd3
    } bank_port_e;

endpackage

// ==== glb_tile_cfg.sv ====
// global buffer tile control
`timescale 1ns/1ps

module glb_tile_cfg import glb_reg_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_cyc,
    input  logic                  cfg_stb,
    input  logic                  cfg_we,
    input  logic [3:0]            cfg_adr,
    input  logic [DATA_WIDTH-1:0] cfg_dat_w,
    input  logic                  stall,
    input  logic                  st_busy,
    input  logic                  ld_busy,
    input  logic                  st_done,
    input  logic                  ld_done,
    output logic [DATA_WIDTH-1:0] cfg_dat_r,
    output logic                  cfg_ack,
    output logic                  st_start,
    output logic [ADDR_WIDTH-1:0] st_addr,
    output logic [ADDR_WIDTH-1:0] st_count,
    output logic                  ld_start,
    output logic [ADDR_WIDTH-1:0] ld_addr,
    output logic [ADDR_WIDTH-1:0] ld_count,
    output logic                  ld_run_en,
    output logic                  strm_f2g_interrupt_pulse,
    output logic                  strm_g2f_interrupt_pulse
);

    logic                  access;
    logic                  wr_en;
    logic                  st_start_req;
    logic                  ld_start_req;
    logic                  st_done_q;
    logic                  ld_done_q;
    logic                  stall_d1;
    logic [DATA_WIDTH-1:0] status_word;
    reg_addr_e             reg_sel;

    // new access, ack low so one ack per transfer
    assign access  = cfg_cyc && cfg_stb && !cfg_ack;
    assign wr_en   = access && cfg_we;
    assign reg_sel = reg_addr_e'(cfg_adr);

    always_comb begin
        status_word                     = '0;
        status_word[STATUS_ST_BUSY_BIT] = st_busy;
        status_word[STATUS_LD_BUSY_BIT] = ld_busy;
        status_word[STATUS_ST_DONE_BIT] = st_done_q;
        status_word[STATUS_LD_DONE_BIT] = ld_done_q;
    end

    // register file and wishbone ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_ack      <= 1'b0;
            st_addr      <= '0;
            st_count     <= '0;
            ld_addr      <= '0;
            ld_count     <= '0;
            st_start_req <= 1'b0;
            ld_start_req <= 1'b0;
            st_done_q    <= 1'b0;
            ld_done_q    <= 1'b0;
        end else begin
            cfg_ack <= access;
            // start bits live one cycle, dropped while that dma runs
            st_start_req <= wr_en && reg_sel == REG_CTRL
                            && cfg_dat_w[CTRL_ST_START_BIT] && !st_busy;
            ld_start_req <= wr_en && reg_sel == REG_CTRL
                            && cfg_dat_w[CTRL_LD_START_BIT] && !ld_busy;
            if (wr_en) begin
                case (reg_sel)
                    REG_ST_ADDR:  st_addr  <= cfg_dat_w[ADDR_WIDTH-1:0];
                    REG_ST_COUNT: st_count <= cfg_dat_w[ADDR_WIDTH-1:0];
                    REG_LD_ADDR:  ld_addr  <= cfg_dat_w[ADDR_WIDTH-1:0];
                    REG_LD_COUNT: ld_count <= cfg_dat_w[ADDR_WIDTH-1:0];
                    REG_STATUS: begin
                        if (cfg_dat_w[STATUS_ST_DONE_BIT]) st_done_q <= 1'b0;
                        if (cfg_dat_w[STATUS_LD_DONE_BIT]) ld_done_q <= 1'b0;
                    end
                    default: ;
                endcase
            end
            // set wins over a clear in the same cycle
            if (st_done) st_done_q <= 1'b1;
            if (ld_done) ld_done_q <= 1'b1;
        end
    end

    // read data, valid while ack is high
    always_ff @(posedge clk) begin
        if (access && !cfg_we) begin
            case (reg_sel)
                REG_ST_ADDR:  cfg_dat_r <= DATA_WIDTH'(st_addr);
                REG_ST_COUNT: cfg_dat_r <= DATA_WIDTH'(st_count);
                REG_LD_ADDR:  cfg_dat_r <= DATA_WIDTH'(ld_addr);
                REG_LD_COUNT: cfg_dat_r <= DATA_WIDTH'(ld_count);
                REG_STATUS:   cfg_dat_r <= status_word;
                default:      cfg_dat_r <= '0;
            endcase
        end
    end

    // one register stage each for start, interrupt and stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_start                 <= 1'b0;
            ld_start                 <= 1'b0;
            strm_f2g_interrupt_pulse <= 1'b0;
            strm_g2f_interrupt_pulse <= 1'b0;
            stall_d1                 <= 1'b0;
        end else begin
            st_start                 <= st_start_req;
            ld_start                 <= ld_start_req;
            strm_f2g_interrupt_pulse <= st_done;
            strm_g2f_interrupt_pulse <= ld_done;
            stall_d1                 <= stall;
        end
    end

    assign ld_run_en = !stall_d1;

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        cfg_ack |=> !cfg_ack);

    // a start never reaches a dma that is still running
    st_start_idle: assert property (@(posedge clk) disable iff (reset)
        st_start |-> !st_busy);
    ld_start_idle: assert property (@(posedge clk) disable iff (reset)
        ld_start |-> !ld_busy);

endmodule

// ==== glb_bank.sv ====
// global buffer memory bank
`timescale 1ns/1ps

module glb_bank import glb_dma_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  st_req,
    input  logic [ADDR_WIDTH-1:0] st_adr,
    input  logic [DATA_WIDTH-1:0] st_dat,
    input  logic                  ld_req,
    input  logic [ADDR_WIDTH-1:0] ld_adr,
    input  logic                  mem_cyc,
    input  logic                  mem_stb,
    input  logic                  mem_we,
    input  logic [ADDR_WIDTH-1:0] mem_adr,
    input  logic [DATA_WIDTH-1:0] mem_dat_w,
    output logic                  ld_gnt,
    output logic                  ld_rd_valid,
    output logic [DATA_WIDTH-1:0] ld_rd_dat,
    output logic [DATA_WIDTH-1:0] mem_dat_r,
    output logic                  mem_ack
);

    logic [DATA_WIDTH-1:0] mem_q [2**ADDR_WIDTH];
    logic [DATA_WIDTH-1:0] rd_q;
    logic                  host_req;
    logic                  host_gnt;
    logic                  bank_we;
    logic [ADDR_WIDTH-1:0] bank_adr;
    logic [DATA_WIDTH-1:0] bank_wdat;
    bank_port_e            gnt;

    // host waits out its own ack before asking again
    assign host_req = mem_cyc && mem_stb && !mem_ack;

    // fixed priority, store never stalls
    always_comb begin
        gnt = PORT_NONE;
        if (st_req) begin
            gnt = PORT_STORE;
        end else if (ld_req) begin
            gnt = PORT_LOAD;
        end else if (host_req) begin
            gnt = PORT_HOST;
        end
    end

    assign ld_gnt   = (gnt == PORT_LOAD);
    assign host_gnt = (gnt == PORT_HOST);

    // address and data steering
    always_comb begin
        bank_we   = 1'b0;
        bank_adr  = mem_adr;
        bank_wdat = mem_dat_w;
        case (gnt)
            PORT_STORE: begin
                bank_we   = 1'b1;
                bank_adr  = st_adr;
                bank_wdat = st_dat;
            end
            PORT_LOAD: bank_adr = ld_adr;
            PORT_HOST: bank_we  = mem_we;
            default: ;
        endcase
    end

    // single-port array, read data one cycle later
    always_ff @(posedge clk) begin
        if (gnt != PORT_NONE) begin
            if (bank_we) begin
                mem_q[bank_adr] <= bank_wdat;
            end else begin
                rd_q <= mem_q[bank_adr];
            end
        end
    end

    // one read register serves both readers
    assign ld_rd_dat = rd_q;
    assign mem_dat_r = rd_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ld_rd_valid <= 1'b0;
            mem_ack     <= 1'b0;
        end else begin
            ld_rd_valid <= ld_gnt;
            mem_ack     <= host_gnt;
        end
    end

    one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({st_req, ld_gnt, host_gnt}));

endmodule

// ==== glb_store_dma.sv ====
// f2g store dma
`timescale 1ns/1ps

module glb_store_dma import glb_dma_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  st_start,
    input  logic [ADDR_WIDTH-1:0] st_addr,
    input  logic [ADDR_WIDTH-1:0] st_count,
    input  logic [DATA_WIDTH-1:0] stream_data_f2g,
    input  logic                  stream_valid_f2g,
    output logic                  st_req,
    output logic [ADDR_WIDTH-1:0] st_adr,
    output logic [DATA_WIDTH-1:0] st_dat,
    output logic                  st_busy,
    output logic                  st_done
);

    dma_state_e            state;
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] idx;
    logic [ADDR_WIDTH-1:0] last_idx;

    // idle words are dropped, running words go straight to the bank
    assign st_req  = (state == DMA_RUN) && stream_valid_f2g;
    assign st_adr  = base + idx;
    assign st_dat  = stream_data_f2g;
    assign st_busy = (state != DMA_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= DMA_IDLE;
            base     <= '0;
            idx      <= '0;
            last_idx <= '0;
            st_done  <= 1'b0;
        end else begin
            st_done <= 1'b0;
            case (state)
                DMA_IDLE: if (st_start) begin
                    base     <= st_addr;
                    idx      <= '0;
                    // count of zero wraps to a full bank
                    last_idx <= st_count - 1'b1;
                    state    <= DMA_RUN;
                end
                DMA_RUN: if (st_req) begin
                    idx <= idx + 1'b1;
                    if (idx == last_idx) begin
                        st_done <= 1'b1;
                        state   <= DMA_IDLE;
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

endmodule

// ==== glb_load_dma.sv ====
// g2f load dma
`timescale 1ns/1ps

module glb_load_dma import glb_dma_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ld_start,
    input  logic [ADDR_WIDTH-1:0] ld_addr,
    input  logic [ADDR_WIDTH-1:0] ld_count,
    input  logic                  ld_run_en,
    input  logic                  ld_gnt,
    input  logic                  ld_rd_valid,
    input  logic [DATA_WIDTH-1:0] ld_rd_dat,
    output logic                  ld_req,
    output logic [ADDR_WIDTH-1:0] ld_adr,
    output logic                  ld_busy,
    output logic                  ld_done,
    output logic [DATA_WIDTH-1:0] stream_data_g2f,
    output logic                  stream_valid_g2f
);

    dma_state_e            state;
    bank_port_e            rd_owner;
    logic [ADDR_WIDTH-1:0] idx;
    logic [ADDR_WIDTH-1:0] last_idx;

    // no request while stalled, in-flight read still lands
    assign ld_req  = (state == DMA_RUN) && ld_run_en;
    assign ld_busy = (state != DMA_IDLE);

    // only reads this dma was granted go out on the stream
    assign stream_data_g2f  = ld_rd_dat;
    assign stream_valid_g2f = ld_rd_valid && (rd_owner == PORT_LOAD);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= DMA_IDLE;
            rd_owner <= PORT_NONE;
            ld_adr   <= '0;
            idx      <= '0;
            last_idx <= '0;
            ld_done  <= 1'b0;
        end else begin
            ld_done  <= 1'b0;
            rd_owner <= (ld_req && ld_gnt) ? PORT_LOAD : PORT_NONE;
            case (state)
                DMA_IDLE: if (ld_start) begin
                    ld_adr   <= ld_addr;
                    idx      <= '0;
                    last_idx <= ld_count - 1'b1;
                    state    <= DMA_RUN;
                end
                // address moves only on a grant, keeps order
                DMA_RUN: if (ld_req && ld_gnt) begin
                    ld_adr <= ld_adr + 1'b1;
                    idx    <= idx + 1'b1;
                    if (idx == last_idx) begin
                        state <= DMA_DRAIN;
                    end
                end
                // wait for the last word before done
                DMA_DRAIN: if (stream_valid_g2f) begin
                    ld_done <= 1'b1;
                    state   <= DMA_IDLE;
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

endmodule

// ==== glb_tile.sv ====
// global buffer tile top
`timescale 1ns/1ps

module glb_tile #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    // configuration wishbone slave
    input  logic                  cfg_cyc,
    input  logic                  cfg_stb,
    input  logic                  cfg_we,
    input  logic [3:0]            cfg_adr,
    input  logic [DATA_WIDTH-1:0] cfg_dat_w,
    output logic [DATA_WIDTH-1:0] cfg_dat_r,
    output logic                  cfg_ack,
    // host memory wishbone slave
    input  logic                  mem_cyc,
    input  logic                  mem_stb,
    input  logic                  mem_we,
    input  logic [ADDR_WIDTH-1:0] mem_adr,
    input  logic [DATA_WIDTH-1:0] mem_dat_w,
    output logic [DATA_WIDTH-1:0] mem_dat_r,
    output logic                  mem_ack,
    // stream in and out
    input  logic [DATA_WIDTH-1:0] stream_data_f2g,
    input  logic                  stream_valid_f2g,
    output logic [DATA_WIDTH-1:0] stream_data_g2f,
    output logic                  stream_valid_g2f,
    // interrupts
    output logic                  strm_f2g_interrupt_pulse,
    output logic                  strm_g2f_interrupt_pulse
);

    logic                  st_start;
    logic [ADDR_WIDTH-1:0] st_addr;
    logic [ADDR_WIDTH-1:0] st_count;
    logic                  st_busy;
    logic                  st_done;
    logic                  st_req;
    logic [ADDR_WIDTH-1:0] st_adr;
    logic [DATA_WIDTH-1:0] st_dat;
    logic                  ld_start;
    logic [ADDR_WIDTH-1:0] ld_addr;
    logic [ADDR_WIDTH-1:0] ld_count;
    logic                  ld_run_en;
    logic                  ld_busy;
    logic                  ld_done;
    logic                  ld_req;
    logic [ADDR_WIDTH-1:0] ld_adr;
    logic                  ld_gnt;
    logic                  ld_rd_valid;
    logic [DATA_WIDTH-1:0] ld_rd_dat;

    // registers, start and interrupt pipelines
    glb_tile_cfg #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) glb_tile_cfg_i (.*);

    // shared bank, store over load over host
    glb_bank #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) glb_bank_i (.*);

    glb_store_dma #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) glb_store_dma_i (.*);

    glb_load_dma #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) glb_load_dma_i (.*);

endmodule

// ==== glb_tile_checker.sv ====
// global buffer tile port monitor
`timescale 1ns/1ps

module glb_tile_checker import glb_reg_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  cfg_we,
    input  logic [3:0]            cfg_adr,
    input  logic [DATA_WIDTH-1:0] cfg_dat_w,
    input  logic [DATA_WIDTH-1:0] cfg_dat_r,
    input  logic                  cfg_ack,
    input  logic                  mem_we,
    input  logic [ADDR_WIDTH-1:0] mem_adr,
    input  logic [DATA_WIDTH-1:0] mem_dat_w,
    input  logic [DATA_WIDTH-1:0] mem_dat_r,
    input  logic                  mem_ack,
    input  logic [DATA_WIDTH-1:0] stream_data_g2f,
    input  logic                  stream_valid_g2f,
    input  logic                  strm_f2g_interrupt_pulse,
    input  logic                  strm_g2f_interrupt_pulse
);

    logic [DATA_WIDTH-1:0] model [2**ADDR_WIDTH];
    logic [DATA_WIDTH-1:0] cfg_expect [$];
    logic [DATA_WIDTH-1:0] mem_expect [$];
    logic [DATA_WIDTH-1:0] exp_word;
    logic                  ack_d1 = 1'b0;
    logic [1:0]            stall_hist = 2'b00;
    int errors     = 0;
    int st_starts  = 0;
    int ld_starts  = 0;
    int f2g_irqs   = 0;
    int g2f_irqs   = 0;
    int ld_addr_w  = 0;
    int ld_count_w = 0;
    int ld_base    = 0;
    int ld_len     = 0;
    int ld_idx     = 0;

    task automatic mismatch(input string name, input logic [DATA_WIDTH-1:0] exp,
                            input logic [DATA_WIDTH-1:0] got);
        errors++;
        $display("error %s expected %h got %h", name, exp, got);
    endtask

    task automatic fail_note(input string what);
        errors++;
        $display("%s at %0t ns", what, $time);
    endtask

    task automatic record_burst_word(input logic [ADDR_WIDTH-1:0] adr,
                                     input logic [DATA_WIDTH-1:0] word);
        model[adr] = word;
    endtask

    task automatic expect_cfg_read(input logic [DATA_WIDTH-1:0] word);
        cfg_expect.push_back(word);
    endtask

    task automatic expect_mem_read(input logic [DATA_WIDTH-1:0] word);
        mem_expect.push_back(word);
    endtask

    task automatic expect_model_read(input logic [ADDR_WIDTH-1:0] adr);
        mem_expect.push_back(model[adr]);
    endtask

    // one interrupt per start, nothing missing
    task automatic check_interrupt_totals();
        if (f2g_irqs != st_starts) begin
            fail_note($sformatf("%0d store starts but %0d f2g interrupts",
                                st_starts, f2g_irqs));
        end
        if (g2f_irqs != ld_starts) begin
            fail_note($sformatf("%0d load starts but %0d g2f interrupts",
                                ld_starts, g2f_irqs));
        end
    endtask

    // sampled on the rising edge, inputs settled since the falling edge
    always @(posedge clk) begin
        if (!reset) begin
            if (cfg_ack && ack_d1) begin
                fail_note("cfg_ack stayed high for two cycles");
            end
            ack_d1 = cfg_ack;
            // track config writes for the load window
            if (cfg_ack && cfg_we) begin
                case (cfg_adr)
                    REG_LD_ADDR:  ld_addr_w  = cfg_dat_w[ADDR_WIDTH-1:0];
                    REG_LD_COUNT: ld_count_w = cfg_dat_w[ADDR_WIDTH-1:0];
                    REG_CTRL: begin
                        if (cfg_dat_w[CTRL_ST_START_BIT]) begin
                            st_starts++;
                        end
                        if (cfg_dat_w[CTRL_LD_START_BIT]) begin
                            ld_starts++;
                            ld_base = ld_addr_w;
                            ld_len  = ld_count_w;
                            ld_idx  = 0;
                        end
                    end
                    default: ;
                endcase
            end
            // status polls carry no expectation
            if (cfg_ack && !cfg_we && cfg_expect.size() > 0) begin
                exp_word = cfg_expect.pop_front();
                if (cfg_dat_r !== exp_word) begin
                    mismatch("cfg_dat_r", exp_word, cfg_dat_r);
                end
            end
            if (mem_ack && mem_we) begin
                model[mem_adr] = mem_dat_w;
            end else if (mem_ack) begin
                if (mem_expect.size() == 0) begin
                    fail_note("host read acknowledged with no read pending");
                end else begin
                    exp_word = mem_expect.pop_front();
                    if (mem_dat_r !== exp_word) begin
                        mismatch("mem_dat_r", exp_word, mem_dat_r);
                    end
                end
            end
            // g2f words in address order from the load base
            if (stream_valid_g2f) begin
                if (ld_idx >= ld_len) begin
                    fail_note("g2f word arrived beyond the load count");
                end else begin
                    exp_word = model[ADDR_WIDTH'(ld_base + ld_idx)];
                    if (stream_data_g2f !== exp_word) begin
                        mismatch("stream_data_g2f", exp_word, stream_data_g2f);
                    end
                end
                ld_idx++;
            end
            // two edges into a stall the last granted word has left
            if (stall && stall_hist == 2'b11 && stream_valid_g2f) begin
                fail_note("g2f word sent while the load was stalled");
            end
            stall_hist = {stall_hist[0], stall};
            if (strm_f2g_interrupt_pulse) begin
                f2g_irqs++;
                if (f2g_irqs > st_starts) begin
                    fail_note("f2g interrupt without a matching store start");
                end
            end
            if (strm_g2f_interrupt_pulse) begin
                g2f_irqs++;
                if (g2f_irqs > ld_starts) begin
                    fail_note("g2f interrupt without a matching load start");
                end else if (ld_idx != ld_len) begin
                    fail_note($sformatf("g2f interrupt after %0d of %0d words",
                                        ld_idx, ld_len));
                end
            end
        end
    end

endmodule

// ==== tb_glb_tile.sv ====
// global buffer tile testbench
`timescale 1ns/1ps

module tb_glb_tile import glb_reg_pkg::*; ();

    localparam int DATA_WIDTH  = 16;
    localparam int ADDR_WIDTH  = 8;
    localparam int ACK_TIMEOUT = 1000;
    localparam int IRQ_TIMEOUT = 2000;
    localparam int POLL_LIMIT  = 20;

    logic                  clk;
    logic                  reset;
    logic                  stall;
    logic                  cfg_cyc;
    logic                  cfg_stb;
    logic                  cfg_we;
    logic [3:0]            cfg_adr;
    logic [DATA_WIDTH-1:0] cfg_dat_w;
    logic [DATA_WIDTH-1:0] cfg_dat_r;
    logic                  cfg_ack;
    logic                  mem_cyc;
    logic                  mem_stb;
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_adr;
    logic [DATA_WIDTH-1:0] mem_dat_w;
    logic [DATA_WIDTH-1:0] mem_dat_r;
    logic                  mem_ack;
    logic [DATA_WIDTH-1:0] stream_data_f2g;
    logic                  stream_valid_f2g;
    logic [DATA_WIDTH-1:0] stream_data_g2f;
    logic                  stream_valid_g2f;
    logic                  strm_f2g_interrupt_pulse;
    logic                  strm_g2f_interrupt_pulse;

    integer                seed;
    int                    run_failures;
    int                    fd;
    int                    code;
    int                    ch;
    logic                  reading;
    logic [7:0]            op;
    logic [31:0]           fa;
    logic [31:0]           fb;
    logic [DATA_WIDTH-1:0] rd_word;

    glb_tile #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) glb_tile_i (.*);

    // passive monitor, owns the model memory
    glb_tile_checker #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) checker_i (.*);

    always #4 clk = ~clk;

    // one wishbone transfer on the config port
    task automatic cfg_access(input logic we, input logic [3:0] adr,
                              input logic [DATA_WIDTH-1:0] wdat,
                              output logic [DATA_WIDTH-1:0] rdat);
        int wait_cycles;
        @(negedge clk);
        cfg_cyc   = 1'b1;
        cfg_stb   = 1'b1;
        cfg_we    = we;
        cfg_adr   = adr;
        cfg_dat_w = wdat;
        wait_cycles = 0;
        @(negedge clk);
        while (!cfg_ack && wait_cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!cfg_ack) begin
            run_failures++;
            $display("timeout waiting for cfg_ack on register %0h", adr);
        end
        rdat = cfg_dat_r;
        // adr, we and data stay put for the monitor
        cfg_cyc = 1'b0;
        cfg_stb = 1'b0;
    endtask

    // one wishbone transfer on the host memory port
    task automatic mem_access(input logic we, input logic [ADDR_WIDTH-1:0] adr,
                              input logic [DATA_WIDTH-1:0] wdat);
        int wait_cycles;
        @(negedge clk);
        mem_cyc   = 1'b1;
        mem_stb   = 1'b1;
        mem_we    = we;
        mem_adr   = adr;
        mem_dat_w = wdat;
        wait_cycles = 0;
        @(negedge clk);
        // host is lowest priority, may wait out a whole dma run
        while (!mem_ack && wait_cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!mem_ack) begin
            run_failures++;
            $display("timeout waiting for mem_ack at address %0h", adr);
        end
        mem_cyc = 1'b0;
        mem_stb = 1'b0;
    endtask

    // start is registered, so wait until the store dma reports busy
    task automatic poll_store_busy();
        logic [DATA_WIDTH-1:0] status;
        int                    polls;
        status = '0;
        polls  = 0;
        while (!status[STATUS_ST_BUSY_BIT] && polls < POLL_LIMIT) begin
            cfg_access(1'b0, REG_STATUS, '0, status);
            polls++;
        end
        if (!status[STATUS_ST_BUSY_BIT]) begin
            run_failures++;
            $display("store dma never reported busy after its start");
        end
    endtask

    // random words with random gaps, every valid word is taken
    task automatic stream_burst(input int base, input int count);
        logic [DATA_WIDTH-1:0] word;
        int                    sent;
        int                    guard;
        poll_store_busy();
        sent  = 0;
        guard = 0;
        while (sent < count && guard < 8 * count + 32) begin
            @(negedge clk);
            guard++;
            if (($random(seed) & 3) != 0) begin
                word             = $random(seed);
                stream_data_f2g  = word;
                stream_valid_f2g = 1'b1;
                checker_i.record_burst_word(ADDR_WIDTH'(base + sent), word);
                sent++;
            end else begin
                stream_valid_f2g = 1'b0;
            end
        end
        @(negedge clk);
        stream_valid_f2g = 1'b0;
        if (sent < count) begin
            run_failures++;
            $display("stream burst sent only %0d of %0d words", sent, count);
        end
    endtask

    // which 0 is f2g, 1 is g2f; total is the running interrupt count
    task automatic wait_interrupt(input logic which, input int total);
        int wait_cycles;
        wait_cycles = 0;
        while ((which ? checker_i.g2f_irqs : checker_i.f2g_irqs) < total
               && wait_cycles < IRQ_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if ((which ? checker_i.g2f_irqs : checker_i.f2g_irqs) < total) begin
            run_failures++;
            $display("timeout waiting for %s interrupt number %0d",
                     which ? "g2f" : "f2g", total);
        end
    endtask

    task automatic run_record(input logic [7:0] code_op, input logic [31:0] a,
                              input logic [31:0] b);
        int i;
        case (code_op)
            "W": cfg_access(1'b1, a[3:0], b[DATA_WIDTH-1:0], rd_word);
            "R": begin
                checker_i.expect_cfg_read(b[DATA_WIDTH-1:0]);
                cfg_access(1'b0, a[3:0], '0, rd_word);
            end
            "M": mem_access(1'b1, a[ADDR_WIDTH-1:0], b[DATA_WIDTH-1:0]);
            "N": begin
                checker_i.expect_mem_read(b[DATA_WIDTH-1:0]);
                mem_access(1'b0, a[ADDR_WIDTH-1:0], '0);
            end
            // host reads checked against the burst copy
            "V": for (i = 0; i < b; i++) begin
                checker_i.expect_model_read(ADDR_WIDTH'(a + i));
                mem_access(1'b0, ADDR_WIDTH'(a + i), '0);
            end
            "B": stream_burst(a, b);
            "I": wait_interrupt(a[0], b);
            "S": begin
                @(negedge clk);
                stall = a[0];
            end
            "D": repeat (a) @(negedge clk);
            default: begin
                run_failures++;
                $display("unknown trace record %c", code_op);
            end
        endcase
    endtask

    initial begin
        clk              = 1'b0;
        reset            = 1'b1;
        stall            = 1'b0;
        cfg_cyc          = 1'b0;
        cfg_stb          = 1'b0;
        cfg_we           = 1'b0;
        cfg_adr          = '0;
        cfg_dat_w        = '0;
        mem_cyc          = 1'b0;
        mem_stb          = 1'b0;
        mem_we           = 1'b0;
        mem_adr          = '0;
        mem_dat_w        = '0;
        stream_data_f2g  = '0;
        stream_valid_f2g = 1'b0;
        seed             = 32'hd2b9;
        run_failures     = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        fd = $fopen("glb_tile_trace.txt", "r");
        if (fd == 0) begin
            run_failures++;
            $display("could not open glb_tile_trace.txt");
        end else begin
            reading = 1'b1;
            while (reading) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) begin
                    reading = 1'b0;
                end else if (op == "#") begin
                    // comment line, skip to its end
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%h %h", fa, fb);
                    run_record(op, fa, fb);
                end
            end
            $fclose(fd);
        end
        repeat (4) @(negedge clk);
        checker_i.check_interrupt_totals();
        $display("closing counts: %0d check errors, %0d run failures",
                 checker_i.errors, run_failures);
        if (checker_i.errors == 0 && run_failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== glb_tile_trace.txt ====
# columns are op then two hex fields a and b
# W R cfg write and read, M N host write and read, B burst, V verify, I irq, S stall, D idle
W 1 0010
R 1 0010
W 2 000c
R 2 000c
W 3 0040
R 3 0040
W 4 0006
R 4 0006
M 80 1234
M 81 beef
N 80 1234
N 81 beef
# store burst of twelve words at 0x10, then status done bit and its clear
W 0 0001
B 10 c
I 0 1
V 10 c
R 5 0004
W 5 0004
R 5 0000
# plain load of twelve words
W 3 0010
W 4 000c
W 0 0002
I 1 1
# load paused by stall after the first words
W 3 0012
W 4 0008
W 0 0002
D 2 0
S 1 0
D 6 0
S 0 0
I 1 2
# host read while a load holds the bank
W 3 0010
W 4 000a
W 0 0002
D 3 0
N 81 beef
I 1 3
R 5 0008

// ==== compile.f ====
glb_reg_pkg.sv
glb_dma_pkg.sv
glb_tile_cfg.sv
glb_bank.sv
glb_store_dma.sv
glb_load_dma.sv
glb_tile.sv
glb_tile_checker.sv
tb_glb_tile.sv
